//--- Bender.yml
package:
  name: leaf_i4o6

sources:
  - verilog/leaf_pkg.sv
  - verilog/leaf_port_fifo.sv
  - verilog/leaf_depacketizer.sv
  - verilog/leaf_packetizer.sv
  - verilog/leaf_interface.sv
  - verilog/user_kernel.sv
  - verilog/leaf_i4o6.sv
  - target: simulation
    files:
      - testbench/tb_leaf_i4o6.sv

//--- flist.f
verilog/leaf_pkg.sv
verilog/leaf_port_fifo.sv
verilog/leaf_depacketizer.sv
verilog/leaf_packetizer.sv
verilog/leaf_interface.sv
verilog/user_kernel.sv
verilog/leaf_i4o6.sv
testbench/tb_leaf_i4o6.sv

//--- testbench/tb_leaf_i4o6.sv
`timescale 1ns/1ps

module tb_leaf_i4o6;

    localparam logic [leaf_pkg::leaf_bits-1:0] local_leaf   = 5'd1;
    localparam logic [leaf_pkg::leaf_bits-1:0] foreign_leaf = 5'd9;
    localparam logic [leaf_pkg::leaf_bits-1:0] net_leaf     = 5'd2;
    localparam int seq_lsb   = leaf_pkg::payload_bits;
    localparam int port_lsb  = seq_lsb + leaf_pkg::seq_bits;
    localparam int leaf_lsb  = port_lsb + leaf_pkg::port_bits;
    localparam int n_out     = leaf_pkg::num_out_ports;
    localparam int num_ports = 1 << leaf_pkg::port_bits;

    logic                             clk;
    logic                             rst_n;
    logic [leaf_pkg::packet_bits-1:0] din;
    logic [leaf_pkg::packet_bits-1:0] dout;
    logic                             resend;
    logic                             ap_start;

    // stream k is configured to leave on port k+1, so rx_q is indexed by port
    logic [leaf_pkg::payload_bits-1:0] exp_q [n_out][$];
    logic [port_lsb-1:0]               rx_q [num_ports][$];
    logic [leaf_pkg::seq_bits-1:0]     exp_seq [n_out];
    integer                            seed;
    int                                error_count;
    int                                check_count;

    leaf_i4o6 #(
        .fifo_depth (16),
        .this_leaf  (local_leaf)
    ) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .din      (din),
        .dout     (dout),
        .resend   (resend),
        .ap_start (ap_start)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // monitor, sampled in the middle of the cycle
    // --------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && resend) begin
            check_count++;
            assert (dout == '0) else begin
                error_count++;
                $display("error: dout got %h during resend, expected %h", dout, 49'h0);
            end
        end
        if (rst_n && dout[leaf_pkg::packet_bits-1]) begin
            check_count++;
            assert (dout[leaf_lsb +: leaf_pkg::leaf_bits] == net_leaf) else begin
                error_count++;
                $display("error: dout leaf got %h expected %h",
                         dout[leaf_lsb +: leaf_pkg::leaf_bits], net_leaf);
            end
            rx_q[dout[port_lsb +: leaf_pkg::port_bits]].push_back(dout[port_lsb-1:0]);
        end
    end

    function automatic logic [leaf_pkg::packet_bits-1:0] make_packet(
        input logic [leaf_pkg::leaf_bits-1:0]    leaf,
        input logic [leaf_pkg::port_bits-1:0]    port,
        input logic [leaf_pkg::payload_bits-1:0] payload
    );
        return {1'b1, leaf, port, {leaf_pkg::seq_bits{1'b0}}, payload};
    endfunction

    function automatic int total_received();
        int total;
        total = 0;
        for (int p = 0; p < num_ports; p++) begin
            total += rx_q[p].size();
        end
        return total;
    endfunction

    task automatic send_word(input logic [leaf_pkg::packet_bits-1:0] word);
        @(posedge clk);
        din <= word;
    endtask

    // config payload: stream in 2:0, leaf in 8:4, port in 12:9
    task automatic send_config(input int stream, input logic [4:0] leaf, input logic [3:0] port);
        logic [leaf_pkg::payload_bits-1:0] payload;
        payload        = '0;
        payload[2:0]   = 3'(stream);
        payload[8:4]   = leaf;
        payload[12:9]  = port;
        send_word(make_packet(local_leaf, 4'd0, payload));
    endtask

    // inputs 1 and 2 feed outputs 1, 2 and the sum on output 5
    task automatic send_pair_ab();
        logic [31:0] a;
        logic [31:0] b;
        a = $random(seed);
        b = $random(seed);
        send_word(make_packet(local_leaf, 4'd1, a));
        send_word(make_packet(local_leaf, 4'd2, b));
        exp_q[0].push_back(a + 32'd1);
        exp_q[1].push_back(b + 32'd1);
        exp_q[4].push_back(a + b);
    endtask

    // inputs 3 and 4 feed outputs 3, 4 and the xor on output 6
    task automatic send_pair_cd();
        logic [31:0] c;
        logic [31:0] d;
        c = $random(seed);
        d = $random(seed);
        send_word(make_packet(local_leaf, 4'd3, c));
        send_word(make_packet(local_leaf, 4'd4, d));
        exp_q[2].push_back(c + 32'd1);
        exp_q[3].push_back(d + 32'd1);
        exp_q[5].push_back(c ^ d);
    endtask

    task automatic compare_field(input string name, input int stream,
                                 input logic [31:0] got, input logic [31:0] expected);
        check_count++;
        assert (got === expected) else begin
            error_count++;
            $display("error: %s on stream %0d got %h expected %h", name, stream, got, expected);
        end
    endtask

    task automatic wait_for_outputs(input int limit);
        int cycles;
        bit done;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < limit) begin
            @(posedge clk);
            cycles++;
            done = 1'b1;
            for (int k = 0; k < n_out; k++) begin
                if (rx_q[k + 1].size() < exp_q[k].size()) begin
                    done = 1'b0;
                end
            end
        end
        if (!done) begin
            error_count++;
            $display("timeout: expected packets did not reach dout within %0d cycles", limit);
        end
        // late extra packets get a chance to show up
        repeat (20) @(posedge clk);
    endtask

    task automatic check_outputs();
        logic [port_lsb-1:0] entry;
        for (int k = 0; k < n_out; k++) begin
            while (exp_q[k].size() > 0) begin
                if (rx_q[k + 1].size() == 0) begin
                    error_count++;
                    $display("stream %0d is missing %0d packets", k + 1, exp_q[k].size());
                    exp_q[k].delete();
                end else begin
                    entry = rx_q[k + 1].pop_front();
                    compare_field("dout.payload", k + 1, entry[seq_lsb-1:0], exp_q[k].pop_front());
                    compare_field("dout.seq", k + 1, 32'(entry[port_lsb-1:seq_lsb]),
                                  32'(exp_seq[k]));
                    exp_seq[k] = exp_seq[k] + 1'b1;
                end
            end
        end
        check_count++;
        assert (total_received() == 0) else begin
            error_count++;
            $display("%0d packets reached dout that were not expected", total_received());
            for (int p = 0; p < num_ports; p++) begin
                rx_q[p].delete();
            end
        end
    endtask

    task automatic expect_quiet(input int cycles, input string reason);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
        end
        check_count++;
        assert (total_received() == 0) else begin
            error_count++;
            $display("%0d packets left the leaf %s", total_received(), reason);
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic unconfigured_stall();
        @(posedge clk);
        ap_start <= 1'b1;
        repeat (2) @(posedge clk);
        send_pair_ab();
        send_pair_ab();
        send_word('0);
        expect_quiet(200, "before any stream was configured");
    endtask

    task automatic config_then_sum();
        for (int k = 0; k < n_out; k++) begin
            send_config(k, net_leaf, 4'(k + 1));
        end
        for (int i = 0; i < 6; i++) begin
            send_pair_ab();
        end
        send_word('0);
        wait_for_outputs(500);
        check_outputs();
    endtask

    task automatic increment_and_xor();
        for (int i = 0; i < 6; i++) begin
            send_pair_cd();
        end
        send_word('0);
        wait_for_outputs(500);
        check_outputs();
    endtask

    task automatic full_burst();
        for (int i = 0; i < 20; i++) begin
            send_pair_ab();
            send_pair_cd();
        end
        send_word('0);
        wait_for_outputs(3000);
        check_outputs();
    endtask

    // ten pairs per port fit in the queues while nothing drains
    task automatic resend_hold();
        @(posedge clk);
        resend <= 1'b1;
        for (int i = 0; i < 10; i++) begin
            send_pair_ab();
            send_pair_cd();
        end
        send_word('0);
        expect_quiet(50, "while resend was high");
        @(posedge clk);
        resend <= 1'b0;
        wait_for_outputs(2000);
        check_outputs();
    endtask

    task automatic foreign_leaf_drop();
        for (int i = 0; i < 3; i++) begin
            for (int p = 1; p <= leaf_pkg::num_in_ports; p++) begin
                send_word(make_packet(foreign_leaf, 4'(p), $random(seed)));
            end
        end
        send_word('0);
        expect_quiet(100, "for packets addressed to another leaf");
    endtask

    initial begin
        seed        = 32'h4511c900;
        error_count = 0;
        check_count = 0;
        din         = '0;
        resend      = 1'b0;
        ap_start    = 1'b0;
        rst_n       = 1'b0;
        for (int k = 0; k < n_out; k++) begin
            exp_seq[k] = '0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        unconfigured_stall();
        config_then_sum();
        increment_and_xor();
        full_burst();
        resend_hold();
        foreign_leaf_drop();

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/leaf_depacketizer.sv
`timescale 1ns/1ps

module leaf_depacketizer #(
    parameter logic [leaf_pkg::leaf_bits-1:0] this_leaf = '0
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [leaf_pkg::packet_bits-1:0]     din,
    output logic [leaf_pkg::num_in_ports-1:0]    wr_en,
    output logic [leaf_pkg::payload_bits-1:0]    wr_data,
    input  logic [leaf_pkg::num_in_ports-1:0]    full,
    output logic                                 cfg_we,
    output logic [2:0]                           cfg_index,
    output logic [leaf_pkg::leaf_bits-1:0]       cfg_leaf,
    output logic [leaf_pkg::port_bits-1:0]       cfg_port
);

    localparam int port_lsb = leaf_pkg::payload_bits + leaf_pkg::seq_bits;
    localparam int leaf_lsb = port_lsb + leaf_pkg::port_bits;

    logic [leaf_pkg::packet_bits-1:0]  din_q;
    logic                              pkt_valid;
    logic [leaf_pkg::leaf_bits-1:0]    pkt_leaf;
    logic [leaf_pkg::port_bits-1:0]    pkt_port;
    logic [leaf_pkg::payload_bits-1:0] pkt_payload;
    leaf_pkg::pkt_kind_e               kind;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            din_q <= '0;
        end else begin
            din_q <= din;
        end
    end

    assign pkt_valid   = din_q[leaf_pkg::packet_bits-1];
    assign pkt_leaf    = din_q[leaf_lsb +: leaf_pkg::leaf_bits];
    assign pkt_port    = din_q[port_lsb +: leaf_pkg::port_bits];
    assign pkt_payload = din_q[leaf_pkg::payload_bits-1:0];

    // words for another leaf are dropped here
    always_comb begin
        if (!pkt_valid || pkt_leaf != this_leaf) begin
            kind = leaf_pkg::pkt_idle;
        end else if (pkt_port == '0) begin
            kind = leaf_pkg::pkt_config;
        end else begin
            kind = leaf_pkg::pkt_data;
        end
    end

    // a word for a full queue is lost
    always_comb begin
        for (int i = 0; i < leaf_pkg::num_in_ports; i++) begin
            wr_en[i] = (kind == leaf_pkg::pkt_data) &&
                       (pkt_port == leaf_pkg::port_bits'(i + 1)) && !full[i];
        end
    end

    assign wr_data = pkt_payload;

    // --------------------------------------------------
    // configuration word: stream 2:0, leaf 8:4, port 12:9
    // --------------------------------------------------
    assign cfg_we    = (kind == leaf_pkg::pkt_config);
    assign cfg_index = pkt_payload[2:0];
    assign cfg_leaf  = pkt_payload[8:4];
    assign cfg_port  = pkt_payload[12:9];

    // the tree only delivers data to ports the kernel has
    assert property (@(posedge clk) disable iff (!rst_n)
        (kind == leaf_pkg::pkt_data) |-> (pkt_port inside {[1:leaf_pkg::num_in_ports]}));

endmodule

//--- verilog/leaf_i4o6.sv
`timescale 1ns/1ps

module leaf_i4o6 #(
    parameter int                             fifo_depth = 16,
    parameter logic [leaf_pkg::leaf_bits-1:0] this_leaf  = 5'd1
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [leaf_pkg::packet_bits-1:0] din,
    output logic [leaf_pkg::packet_bits-1:0] dout,
    input  logic                             resend,
    input  logic                             ap_start
);

    logic                                                           kernel_rst_n;
    logic [leaf_pkg::num_in_ports-1:0]                              in_vld;
    logic [leaf_pkg::num_in_ports-1:0][leaf_pkg::payload_bits-1:0]  in_data;
    logic [leaf_pkg::num_in_ports-1:0]                              in_ack;
    logic [leaf_pkg::num_out_ports-1:0]                             out_vld;
    logic [leaf_pkg::num_out_ports-1:0][leaf_pkg::payload_bits-1:0] out_data;
    logic [leaf_pkg::num_out_ports-1:0]                             out_ack;

    leaf_interface #(
        .fifo_depth (fifo_depth),
        .this_leaf  (this_leaf)
    ) u_interface (
        .clk          (clk),
        .rst_n        (rst_n),
        .din          (din),
        .dout         (dout),
        .resend       (resend),
        .ap_start     (ap_start),
        .kernel_rst_n (kernel_rst_n),
        .in_vld       (in_vld),
        .in_data      (in_data),
        .in_ack       (in_ack),
        .out_vld      (out_vld),
        .out_data     (out_data),
        .out_ack      (out_ack)
    );

    user_kernel u_kernel (
        .clk          (clk),
        .kernel_rst_n (kernel_rst_n),
        .in_vld       (in_vld),
        .in_data      (in_data),
        .in_ack       (in_ack),
        .out_vld      (out_vld),
        .out_data     (out_data),
        .out_ack      (out_ack)
    );

endmodule

//--- verilog/leaf_interface.sv
`timescale 1ns/1ps

module leaf_interface #(
    parameter int                             fifo_depth = 16,
    parameter logic [leaf_pkg::leaf_bits-1:0] this_leaf  = '0
) (
    input  logic                                                           clk,
    input  logic                                                           rst_n,
    input  logic [leaf_pkg::packet_bits-1:0]                               din,
    output logic [leaf_pkg::packet_bits-1:0]                               dout,
    input  logic                                                           resend,
    input  logic                                                           ap_start,
    output logic                                                           kernel_rst_n,
    output logic [leaf_pkg::num_in_ports-1:0]                              in_vld,
    output logic [leaf_pkg::num_in_ports-1:0][leaf_pkg::payload_bits-1:0]  in_data,
    input  logic [leaf_pkg::num_in_ports-1:0]                              in_ack,
    input  logic [leaf_pkg::num_out_ports-1:0]                             out_vld,
    input  logic [leaf_pkg::num_out_ports-1:0][leaf_pkg::payload_bits-1:0] out_data,
    output logic [leaf_pkg::num_out_ports-1:0]                             out_ack
);

    localparam int n_out = leaf_pkg::num_out_ports;

    logic [leaf_pkg::num_in_ports-1:0]              wr_en;
    logic [leaf_pkg::payload_bits-1:0]              wr_data;
    logic [leaf_pkg::num_in_ports-1:0]              full;
    logic                                           cfg_we;
    logic [2:0]                                     cfg_index;
    logic [leaf_pkg::leaf_bits-1:0]                 cfg_leaf;
    logic [leaf_pkg::port_bits-1:0]                 cfg_port;
    logic                                           cfg_hit;
    logic [n_out-1:0][leaf_pkg::leaf_bits-1:0]      dest_leaf;
    logic [n_out-1:0][leaf_pkg::port_bits-1:0]      dest_port;
    logic [n_out-1:0]                               dest_valid;
    leaf_pkg::rst_state_e                           rst_state;

    leaf_depacketizer #(
        .this_leaf (this_leaf)
    ) u_depacketizer (
        .clk       (clk),
        .rst_n     (rst_n),
        .din       (din),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .full      (full),
        .cfg_we    (cfg_we),
        .cfg_index (cfg_index),
        .cfg_leaf  (cfg_leaf),
        .cfg_port  (cfg_port)
    );

    for (genvar i = 0; i < leaf_pkg::num_in_ports; i++) begin : g_port
        leaf_port_fifo #(
            .fifo_depth (fifo_depth)
        ) u_fifo (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (wr_en[i]),
            .wr_data (wr_data),
            .full    (full[i]),
            .vld     (in_vld[i]),
            .data    (in_data[i]),
            .ack     (in_ack[i])
        );
    end

    // --------------------------------------------------
    // destination table, one entry per output stream
    // --------------------------------------------------
    assign cfg_hit = cfg_we && (cfg_index < n_out);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dest_valid <= '0;
        end else if (cfg_hit) begin
            dest_valid[cfg_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_hit) begin
            dest_leaf[cfg_index] <= cfg_leaf;
            dest_port[cfg_index] <= cfg_port;
        end
    end

    leaf_packetizer u_packetizer (
        .clk        (clk),
        .rst_n      (rst_n),
        .resend     (resend),
        .vld        (out_vld),
        .data       (out_data),
        .ack        (out_ack),
        .dest_leaf  (dest_leaf),
        .dest_port  (dest_port),
        .dest_valid (dest_valid),
        .dout       (dout)
    );

    // kernel stays in reset until the first ap_start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_state <= leaf_pkg::rst_hold;
        end else if (rst_state == leaf_pkg::rst_hold && ap_start) begin
            rst_state <= leaf_pkg::rst_run;
        end
    end

    assign kernel_rst_n = (rst_state == leaf_pkg::rst_run);

endmodule

//--- verilog/leaf_packetizer.sv
`timescale 1ns/1ps

module leaf_packetizer (
    input  logic                                                           clk,
    input  logic                                                           rst_n,
    input  logic                                                           resend,
    input  logic [leaf_pkg::num_out_ports-1:0]                             vld,
    input  logic [leaf_pkg::num_out_ports-1:0][leaf_pkg::payload_bits-1:0] data,
    output logic [leaf_pkg::num_out_ports-1:0]                             ack,
    input  logic [leaf_pkg::num_out_ports-1:0][leaf_pkg::leaf_bits-1:0]    dest_leaf,
    input  logic [leaf_pkg::num_out_ports-1:0][leaf_pkg::port_bits-1:0]    dest_port,
    input  logic [leaf_pkg::num_out_ports-1:0]                             dest_valid,
    output logic [leaf_pkg::packet_bits-1:0]                               dout
);

    localparam int n        = leaf_pkg::num_out_ports;
    localparam int idx_bits = $clog2(n);

    logic [n-1:0]                         req;
    logic [idx_bits-1:0]                  last_q;
    logic [idx_bits-1:0]                  sel;
    logic                                 grant;
    logic [n-1:0][leaf_pkg::seq_bits-1:0] seq_q;
    logic [leaf_pkg::packet_bits-1:0]     pkt_q;

    // unconfigured streams wait, and nothing moves during resend
    assign req = resend ? '0 : (vld & dest_valid);

    // search starts at the stream after the last grant
    always_comb begin
        int idx;
        ack   = '0;
        sel   = last_q;
        grant = 1'b0;
        for (int i = 1; i <= n; i++) begin
            idx = (int'(last_q) + i) % n;
            if (!grant && req[idx]) begin
                grant    = 1'b1;
                sel      = idx_bits'(idx);
                ack[idx] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q <= idx_bits'(n - 1);
            seq_q  <= '0;
            pkt_q  <= '0;
        end else begin
            if (grant) begin
                last_q     <= sel;
                seq_q[sel] <= seq_q[sel] + 1'b1;
                pkt_q      <= {1'b1, dest_leaf[sel], dest_port[sel], seq_q[sel], data[sel]};
            end else if (!resend) begin
                pkt_q <= '0;
            end
        end
    end

    // a packet caught by a rising resend is kept and sent once resend drops
    assign dout = resend ? '0 : pkt_q;

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ack));

endmodule

//--- verilog/leaf_pkg.sv
package leaf_pkg;

    // --------------------------------------------------
    // network word layout, msb first
    // valid | leaf | port | seq | payload
    // --------------------------------------------------
    localparam int packet_bits  = 49;
    localparam int payload_bits = 32;
    localparam int leaf_bits    = 5;
    localparam int port_bits    = 4;
    localparam int seq_bits     = 7;

    localparam int num_in_ports  = 4;
    localparam int num_out_ports = 6;

    // classification of the registered incoming word
    typedef enum logic [1:0] {
        pkt_idle,
        pkt_config,
        pkt_data
    } pkt_kind_e;

    // kernel release state
    typedef enum logic [1:0] {
        rst_hold,
        rst_run
    } rst_state_e;

endpackage

//--- verilog/leaf_port_fifo.sv
`timescale 1ns/1ps

module leaf_port_fifo #(
    parameter int fifo_depth = 16
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              wr_en,
    input  logic [leaf_pkg::payload_bits-1:0] wr_data,
    output logic                              full,
    output logic                              vld,
    output logic [leaf_pkg::payload_bits-1:0] data,
    input  logic                              ack
);

    localparam int addr_bits = $clog2(fifo_depth);

    logic [leaf_pkg::payload_bits-1:0] mem [fifo_depth];
    logic [addr_bits:0]                wr_ptr;
    logic [addr_bits:0]                rd_ptr;
    logic                              push;
    logic                              pop;

    // the extra top bit of each pointer tells a full queue from an empty one
    assign full = (wr_ptr[addr_bits] != rd_ptr[addr_bits]) &&
                  (wr_ptr[addr_bits-1:0] == rd_ptr[addr_bits-1:0]);
    assign vld  = (wr_ptr != rd_ptr);
    assign data = mem[rd_ptr[addr_bits-1:0]];
    assign push = wr_en && !full;
    assign pop  = ack && vld;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[addr_bits-1:0]] <= wr_data;
        end
    end

    // the kernel only takes a word that this queue presents
    assert property (@(posedge clk) disable iff (!rst_n) ack |-> vld);

endmodule

//--- verilog/user_kernel.sv
`timescale 1ns/1ps

module user_kernel (
    input  logic                                                           clk,
    input  logic                                                           kernel_rst_n,
    input  logic [leaf_pkg::num_in_ports-1:0]                              in_vld,
    input  logic [leaf_pkg::num_in_ports-1:0][leaf_pkg::payload_bits-1:0]  in_data,
    output logic [leaf_pkg::num_in_ports-1:0]                              in_ack,
    output logic [leaf_pkg::num_out_ports-1:0]                             out_vld,
    output logic [leaf_pkg::num_out_ports-1:0][leaf_pkg::payload_bits-1:0] out_data,
    input  logic [leaf_pkg::num_out_ports-1:0]                             out_ack
);

    localparam int n_out = leaf_pkg::num_out_ports;

    logic [n_out-1:0]                             room;
    logic                                         go_a;
    logic                                         go_b;
    logic [n_out-1:0]                             load;
    logic [n_out-1:0][leaf_pkg::payload_bits-1:0] next_data;

    // a slot can take a word when it is empty or being read this cycle
    assign room = ~out_vld | out_ack;

    // both inputs of a pair move together so the pair output sees them side by side
    assign go_a = in_vld[0] && in_vld[1] && room[0] && room[1] && room[4];
    assign go_b = in_vld[2] && in_vld[3] && room[2] && room[3] && room[5];

    assign in_ack = {go_b, go_b, go_a, go_a};
    assign load   = {go_b, go_a, go_b, go_b, go_a, go_a};

    always_comb begin
        for (int k = 0; k < leaf_pkg::num_in_ports; k++) begin
            next_data[k] = in_data[k] + 1'b1;
        end
        next_data[4] = in_data[0] + in_data[1];
        next_data[5] = in_data[2] ^ in_data[3];
    end

    always_ff @(posedge clk or negedge kernel_rst_n) begin
        if (!kernel_rst_n) begin
            out_vld <= '0;
        end else begin
            for (int k = 0; k < n_out; k++) begin
                if (load[k]) begin
                    out_vld[k] <= 1'b1;
                end else if (out_ack[k]) begin
                    out_vld[k] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < n_out; k++) begin
            if (load[k]) begin
                out_data[k] <= next_data[k];
            end
        end
    end

endmodule
